// File: exu_alu_pkg.sv
/*
  Widths, group codes and payload types shared by the integer execute unit.
  The 13-bit decode payload is one word, read through the view selected by grp.
*/
package exu_alu_pkg;

  localparam int XLEN      = 32;
  localparam int PC_SIZE   = 32;
  localparam int RFIDX_W   = 5;
  localparam int ADDER_W   = XLEN + 1;          // One extra bit for signed/unsigned compares
  localparam int DEC_PLD_W = 13;
  localparam int SHAMT_W   = $clog2(XLEN);
  localparam int MUL_STEPS = 32;
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);

  localparam logic [1:0] GRP_ALU    = 2'd0;
  localparam logic [1:0] GRP_BJP    = 2'd1;
  localparam logic [1:0] GRP_MULDIV = 2'd2;
  localparam logic [1:0] GRP_RSV    = 2'd3;     // Treated as an illegal instruction

  // Multiply sequencer states
  localparam logic [1:0] MDV_IDLE = 2'd0;
  localparam logic [1:0] MDV_EXEC = 2'd1;
  localparam logic [1:0] MDV_DONE = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // Decode payload views
  typedef struct packed {
    logic add, sub, xor_op, sll, srl, sra, or_op, and_op;
    logic slt, sltu, lui, op2imm, op1pc;
  } alu_info_t;

  typedef struct packed {
    logic       jump, beq, bne, blt, bge, bltu, bgeu;
    logic       bprdt;                          // Static prediction from IFU
    logic [4:0] spare;
  } bjp_info_t;

  typedef struct packed {
    logic       mul, mulh, mulhsu, mulhu;
    logic [8:0] spare;
  } mdv_info_t;

  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
    mdv_info_t mdv;
  } dec_pld_u;

  typedef struct packed {
    logic [1:0] grp;
    logic       rv32;                           // Low for a 16-bit compressed instruction
    dec_pld_u   pld;
  } dec_info_t;

  typedef struct packed {
    logic [XLEN-1:0]    rs1, rs2, imm;
    logic [PC_SIZE-1:0] pc;
    logic               pc_vld;
    logic [RFIDX_W-1:0] rdidx;
    logic               rdwen;
    logic               ilegl;
    dec_info_t          info;
  } issue_t;

  //////////////////////////////////////////////////////////////////////
  // Datapath requests and results
  typedef struct packed {
    logic [XLEN-1:0] op1, op2;
    logic add, sub, xor_op, sll, srl, sra, or_op, and_op, slt, sltu, lui;
  } alu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] op1, op2;
    logic cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu;
    logic add;
  } bjp_req_t;

  typedef struct packed {
    logic [ADDER_W-1:0] op1, op2;
    logic               add, sub;
    logic               sbf0_ena;
    logic [ADDER_W-1:0] sbf0_nxt;
    logic               sbf1_ena;
    logic [ADDER_W-1:0] sbf1_nxt;
  } mdv_req_t;

  typedef struct packed {
    logic [ADDER_W-1:0] add_res;
    logic [XLEN-1:0]    alu_res;
    logic               cmp_res;
    logic [ADDER_W-1:0] sbf0, sbf1;
  } dpath_res_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] wdat;
  } unit_res_t;

  typedef struct packed {
    logic [PC_SIZE-1:0] pc;
    logic               pc_vld;
    logic [XLEN-1:0]    imm;
    logic               rv32, bjp, bjp_prdt, bjp_rslv, ilegl;
  } cmt_t;

endpackage

// File: exu_alu_rglr.sv
/*
  Regular ALU unit. Single cycle, result comes straight from the shared datapath.
*/
`timescale 1ns/100ps

module exu_alu_rglr import exu_alu_pkg::*; (
  input  logic       i_valid,
  input  issue_t     i_issue,
  output alu_req_t   o_req,
  input  dpath_res_t i_res,
  output unit_res_t  o_res
);

  alu_info_t info;

  assign info = i_issue.info.pld.alu;

  // AUIPC takes pc, immediate forms take imm
  assign o_req.op1 = i_valid ? (info.op1pc ? i_issue.pc : i_issue.rs1) : '0;
  assign o_req.op2 = i_valid ? (info.op2imm ? i_issue.imm : i_issue.rs2) : '0;

  assign o_req.add    = i_valid & info.add;
  assign o_req.sub    = i_valid & info.sub;
  assign o_req.xor_op = i_valid & info.xor_op;
  assign o_req.sll    = i_valid & info.sll;
  assign o_req.srl    = i_valid & info.srl;
  assign o_req.sra    = i_valid & info.sra;
  assign o_req.or_op  = i_valid & info.or_op;
  assign o_req.and_op = i_valid & info.and_op;
  assign o_req.slt    = i_valid & info.slt;
  assign o_req.sltu   = i_valid & info.sltu;
  assign o_req.lui    = i_valid & info.lui;       // Passes op2 through

  assign o_res.valid = i_valid;
  assign o_res.wdat  = i_res.alu_res;

endmodule

// File: exu_alu_bjp.sv
/*
  Branch/jump unit. Resolves conditional branches and builds the JAL/JALR link value.
  Target address calculation is outside this unit.
*/
`timescale 1ns/100ps

module exu_alu_bjp import exu_alu_pkg::*; (
  input  logic       i_valid,
  input  issue_t     i_issue,
  output bjp_req_t   o_req,
  input  dpath_res_t i_res,
  output unit_res_t  o_res,
  output logic       o_bjp,
  output logic       o_prdt,
  output logic       o_rslv
);

  bjp_info_t       info;
  logic            is_jump;
  logic [XLEN-1:0] link_inc;

  assign info     = i_issue.info.pld.bjp;
  assign is_jump  = i_valid & info.jump;
  assign link_inc = i_issue.info.rv32 ? XLEN'(4) : XLEN'(2);

  // Jumps add pc and the instruction size, branches compare rs1 and rs2
  assign o_req.op1 = ~i_valid ? '0 : (info.jump ? i_issue.pc : i_issue.rs1);
  assign o_req.op2 = ~i_valid ? '0 : (info.jump ? link_inc : i_issue.rs2);
  assign o_req.add = is_jump;

  assign o_req.cmp_eq  = i_valid & info.beq;
  assign o_req.cmp_ne  = i_valid & info.bne;
  assign o_req.cmp_lt  = i_valid & info.blt;
  assign o_req.cmp_ge  = i_valid & info.bge;
  assign o_req.cmp_ltu = i_valid & info.bltu;
  assign o_req.cmp_geu = i_valid & info.bgeu;

  assign o_res.valid = i_valid;
  assign o_res.wdat  = i_res.add_res[XLEN-1:0];  // Link value

  assign o_bjp  = i_valid;
  assign o_prdt = i_valid & info.bprdt;
  assign o_rslv = is_jump | (i_valid & i_res.cmp_res);

endmodule

// File: exu_alu_muldiv.sv
/*
  Radix-2 multiply sequencer on the shared 33-bit adder. One load cycle, then
  MUL_STEPS steps; the result is held in DONE until the commit handshake.
  rs1 is the multiplicand and is read from i_issue every step, so it must stay stable.
*/
`timescale 1ns/100ps

module exu_alu_muldiv import exu_alu_pkg::*; (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_valid,
  input  issue_t     i_issue,
  output mdv_req_t   o_req,
  input  dpath_res_t i_res,
  output unit_res_t  o_res,
  input  logic       i_o_ready
);

  mdv_info_t            info;
  logic [1:0]           state_r, state_nxt;
  logic [MUL_CNT_W-1:0] cnt_r;
  logic                 load, step, last;
  logic                 a_signed, b_signed, hi_half, mb, do_sub;
  logic [ADDER_W-1:0]   mcand, sum;

  assign info     = i_issue.info.pld.mdv;
  assign a_signed = info.mulh | info.mulhsu;
  assign b_signed = info.mulh;
  assign hi_half  = info.mulh | info.mulhsu | info.mulhu;
  assign mcand    = {a_signed & i_issue.rs1[XLEN-1], i_issue.rs1};

  assign load   = (state_r == MDV_IDLE) & i_valid;
  assign step   = (state_r == MDV_EXEC) & i_valid;
  assign last   = step & (cnt_r == MUL_CNT_W'(MUL_STEPS - 1));
  assign mb     = i_res.sbf1[0];                // Current multiplier bit
  assign do_sub = last & b_signed & mb;         // MSB of a signed multiplier weighs negative
  assign sum    = i_res.add_res;

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      MDV_IDLE: begin
        if (i_valid) begin
          state_nxt = MDV_EXEC;
        end
      end
      MDV_EXEC: begin
        if (last) begin
          state_nxt = MDV_DONE;
        end
      end
      MDV_DONE: begin
        if (i_o_ready) begin
          state_nxt = MDV_IDLE;                 // Result taken by commit
        end
      end
      default: state_nxt = MDV_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_r <= MDV_IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_nxt;
      if (load) begin
        cnt_r <= '0;
      end else if (step) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath request
  assign o_req.op1 = step ? i_res.sbf0 : '0;   // sbf0 holds the running high part
  assign o_req.op2 = (step & mb) ? mcand : '0;
  assign o_req.add = step & ~do_sub;
  assign o_req.sub = do_sub;

  assign o_req.sbf0_ena = load | step;
  assign o_req.sbf0_nxt = step ? {sum[ADDER_W-1] & a_signed, sum[ADDER_W-1:1]} : '0;
  assign o_req.sbf1_ena = load | step;
  assign o_req.sbf1_nxt = step ? {1'b0, sum[0], i_res.sbf1[XLEN-1:1]} :
                          load ? {1'b0, i_issue.rs2} : '0;

  assign o_res.valid = (state_r == MDV_DONE);
  assign o_res.wdat  = ({XLEN{info.mul}} & i_res.sbf1[XLEN-1:0])
                     | ({XLEN{hi_half}}  & i_res.sbf0[XLEN-1:0]);

endmodule

// File: exu_alu_dpath.sv
/*
  Shared datapath. Requests are ORed, so only one unit may drive a nonzero request.
  The 33-bit adder also serves slt/sltu and the branch compares.
*/
`timescale 1ns/100ps

module exu_alu_dpath import exu_alu_pkg::*; (
  input  logic       clk,
  input  logic       i_reset,
  input  alu_req_t   i_alu,
  input  bjp_req_t   i_bjp,
  input  mdv_req_t   i_mdv,
  output dpath_res_t o_res
);

  logic [XLEN-1:0]    lop1, lop2, xor_res, sra_res;
  logic [SHAMT_W-1:0] shamt;
  logic [ADDER_W-1:0] op1, op2, op2_inv, add_out;
  logic [ADDER_W-1:0] sbf0_r, sbf1_r;
  logic               op_signed, do_add, do_sub, adder_ena, lt, eq;

  assign lop1 = i_alu.op1 | i_bjp.op1;
  assign lop2 = i_alu.op2 | i_bjp.op2;

  // Sign extension only for signed compares
  assign op_signed = i_alu.slt | i_bjp.cmp_lt | i_bjp.cmp_ge;
  assign op1 = {op_signed & lop1[XLEN-1], lop1} | i_mdv.op1;
  assign op2 = {op_signed & lop2[XLEN-1], lop2} | i_mdv.op2;

  //////////////////////////////////////////////////////////////////////
  // Adder
  assign do_sub = i_alu.sub | i_alu.slt | i_alu.sltu | i_bjp.cmp_lt | i_bjp.cmp_ge
                | i_bjp.cmp_ltu | i_bjp.cmp_geu | i_mdv.sub;
  assign do_add    = i_alu.add | i_bjp.add | i_mdv.add;
  assign adder_ena = do_add | do_sub;
  assign op2_inv   = do_sub ? ~op2 : op2;
  assign add_out   = adder_ena ? (op1 + op2_inv + ADDER_W'(do_sub)) : '0;

  assign lt      = add_out[ADDER_W-1];          // Borrow or sign of the extended difference
  assign xor_res = lop1 ^ lop2;
  assign eq      = ~|xor_res;

  // Shifter
  assign shamt   = lop2[SHAMT_W-1:0];
  assign sra_res = $signed(lop1) >>> shamt;

  assign o_res.add_res = add_out;
  assign o_res.cmp_res = (i_bjp.cmp_eq & eq) | (i_bjp.cmp_ne & ~eq)
                       | ((i_bjp.cmp_lt | i_bjp.cmp_ltu) & lt)
                       | ((i_bjp.cmp_ge | i_bjp.cmp_geu) & ~lt);

  assign o_res.alu_res = ({XLEN{i_alu.add | i_alu.sub}}   & add_out[XLEN-1:0])
                       | ({XLEN{i_alu.xor_op}}            & xor_res)
                       | ({XLEN{i_alu.or_op}}             & (lop1 | lop2))
                       | ({XLEN{i_alu.and_op}}            & (lop1 & lop2))
                       | ({XLEN{i_alu.sll}}               & (lop1 << shamt))
                       | ({XLEN{i_alu.srl}}               & (lop1 >> shamt))
                       | ({XLEN{i_alu.sra}}               & sra_res)
                       | ({XLEN{i_alu.slt | i_alu.sltu}}  & XLEN'(lt))
                       | ({XLEN{i_alu.lui}}               & lop2);

  //////////////////////////////////////////////////////////////////////
  // Multiply step registers
  always_ff @(posedge clk) begin
    if (i_reset) begin
      sbf0_r <= '0;
      sbf1_r <= '0;
    end else begin
      if (i_mdv.sbf0_ena) begin
        sbf0_r <= i_mdv.sbf0_nxt;
      end
      if (i_mdv.sbf1_ena) begin
        sbf1_r <= i_mdv.sbf1_nxt;
      end
    end
  end

  assign o_res.sbf0 = sbf0_r;
  assign o_res.sbf1 = sbf1_r;

endmodule

// File: exu_alu_retire.sv
/*
  Result select and joint commit/write-back handshake.
  Selects are one-hot and already qualified by the issue valid.
*/
`timescale 1ns/100ps

module exu_alu_retire import exu_alu_pkg::*; (
  input  logic               i_sel_alu,
  input  logic               i_sel_bjp,
  input  logic               i_sel_mdv,
  input  logic               i_sel_ilegl,
  input  logic               i_rdwen,
  input  logic [RFIDX_W-1:0] i_rdidx,
  input  unit_res_t          i_alu,
  input  unit_res_t          i_bjp,
  input  unit_res_t          i_mdv,
  output logic               o_unit_ready,
  output logic               o_cmt_valid,
  input  logic               i_cmt_ready,
  output logic               o_wbck_valid,
  input  logic               i_wbck_ready,
  output logic [XLEN-1:0]    o_wbck_wdat,
  output logic [RFIDX_W-1:0] o_wbck_rdidx
);

  logic sel_valid;
  logic need_wbck;

  // Illegal path is always ready with zero data
  assign sel_valid = (i_sel_alu & i_alu.valid)
                   | (i_sel_bjp & i_bjp.valid)
                   | (i_sel_mdv & i_mdv.valid)
                   | i_sel_ilegl;

  assign need_wbck = i_rdwen & ~i_sel_ilegl;    // Illegal never writes rd

  // Commit and write-back complete together
  assign o_unit_ready = i_cmt_ready & (~need_wbck | i_wbck_ready);
  assign o_cmt_valid  = sel_valid & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = need_wbck & sel_valid & i_cmt_ready;

  assign o_wbck_wdat  = ({XLEN{i_sel_alu}} & i_alu.wdat)
                      | ({XLEN{i_sel_bjp}} & i_bjp.wdat)
                      | ({XLEN{i_sel_mdv}} & i_mdv.wdat);
  assign o_wbck_rdidx = i_rdidx;

endmodule

// File: exu_alu.sv
/*
  Integer execute unit top. ALU, branch and illegal issues commit in the issue cycle;
  multiplies take MUL_STEPS+1 cycles. i_issue must stay stable until o_ready.
*/
`timescale 1ns/100ps

module exu_alu import exu_alu_pkg::*; (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_valid,
  output logic               o_ready,
  input  issue_t             i_issue,
  output logic               o_cmt_valid,
  input  logic               i_cmt_ready,
  output cmt_t               o_cmt,
  output logic               o_wbck_valid,
  input  logic               i_wbck_ready,
  output logic [XLEN-1:0]    o_wbck_wdat,
  output logic [RFIDX_W-1:0] o_wbck_rdidx
);

  logic       is_ilegl;
  logic       sel_alu, sel_bjp, sel_mdv, sel_ilegl;
  logic       unit_ready;
  logic       bjp_flag, bjp_prdt, bjp_rslv;
  alu_req_t   alu_req;
  bjp_req_t   bjp_req;
  mdv_req_t   mdv_req;
  dpath_res_t dp_res;
  unit_res_t  alu_res, bjp_res, mdv_res;

  //////////////////////////////////////////////////////////////////////
  // Group decode
  assign is_ilegl  = i_issue.ilegl | (i_issue.info.grp == GRP_RSV);  // Overrides the group
  assign sel_alu   = i_valid & ~is_ilegl & (i_issue.info.grp == GRP_ALU);
  assign sel_bjp   = i_valid & ~is_ilegl & (i_issue.info.grp == GRP_BJP);
  assign sel_mdv   = i_valid & ~is_ilegl & (i_issue.info.grp == GRP_MULDIV);
  assign sel_ilegl = i_valid & is_ilegl;

  // Multiply accepts only once its result is out
  assign o_ready = unit_ready & (sel_alu | sel_bjp | sel_ilegl | (sel_mdv & mdv_res.valid));

  exu_alu_rglr exu_alu_rglr_inst (
    .i_valid (sel_alu),
    .i_issue (i_issue),
    .o_req   (alu_req),
    .i_res   (dp_res),
    .o_res   (alu_res)
  );

  exu_alu_bjp exu_alu_bjp_inst (
    .i_valid (sel_bjp),
    .i_issue (i_issue),
    .o_req   (bjp_req),
    .i_res   (dp_res),
    .o_res   (bjp_res),
    .o_bjp   (bjp_flag),
    .o_prdt  (bjp_prdt),
    .o_rslv  (bjp_rslv)
  );

  exu_alu_muldiv exu_alu_muldiv_inst (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_valid   (sel_mdv),
    .i_issue   (i_issue),
    .o_req     (mdv_req),
    .i_res     (dp_res),
    .o_res     (mdv_res),
    .i_o_ready (unit_ready & sel_mdv)
  );

  exu_alu_dpath exu_alu_dpath_inst (
    .clk     (clk),
    .i_reset (i_reset),
    .i_alu   (alu_req),
    .i_bjp   (bjp_req),
    .i_mdv   (mdv_req),
    .o_res   (dp_res)
  );

  exu_alu_retire exu_alu_retire_inst (
    .i_sel_alu    (sel_alu),
    .i_sel_bjp    (sel_bjp),
    .i_sel_mdv    (sel_mdv),
    .i_sel_ilegl  (sel_ilegl),
    .i_rdwen      (i_issue.rdwen),
    .i_rdidx      (i_issue.rdidx),
    .i_alu        (alu_res),
    .i_bjp        (bjp_res),
    .i_mdv        (mdv_res),
    .o_unit_ready (unit_ready),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck_wdat  (o_wbck_wdat),
    .o_wbck_rdidx (o_wbck_rdidx)
  );

  // Commit payload
  assign o_cmt.pc       = i_issue.pc;
  assign o_cmt.pc_vld   = i_issue.pc_vld;
  assign o_cmt.imm      = i_issue.imm;
  assign o_cmt.rv32     = i_issue.info.rv32;
  assign o_cmt.bjp      = bjp_flag;
  assign o_cmt.bjp_prdt = bjp_prdt;
  assign o_cmt.bjp_rslv = bjp_rslv;
  assign o_cmt.ilegl    = is_ilegl;

endmodule

// File: tb_exu_alu.sv
/*
  Directed testbench for the integer execute unit. Inputs change 1 ns after the
  rising edge, outputs are sampled on the falling edge. Stops at the first error.
*/
`timescale 1ns/100ps

module tb_exu_alu import exu_alu_pkg::*; ();

  localparam int N_ALU          = 11 * 4;
  localparam int N_BJP          = 6 * 3 + 2;
  localparam int N_MUL          = 4 * 3 + 1;
  localparam int N_OTHER        = 3 + 3;
  localparam int TIMEOUT_CYCLES = (N_ALU + N_BJP + N_MUL + N_OTHER) * 40;

  logic               clk = 1'b0;
  logic               i_reset, i_valid, i_cmt_ready, i_wbck_ready;
  issue_t             issue;
  logic               o_ready, o_cmt_valid, o_wbck_valid;
  cmt_t               o_cmt;
  logic [XLEN-1:0]    o_wbck_wdat;
  logic [RFIDX_W-1:0] o_wbck_rdidx;
  logic [31:0]        lfsr_state = 32'd93734;
  int                 cycle_cnt = 0;

  always #4 clk = ~clk;                         // 8 ns period

  exu_alu exu_alu_inst (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_issue      (issue),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck_wdat  (o_wbck_wdat),
    .o_wbck_rdidx (o_wbck_rdidx)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      stop_on_error();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and stimulus helpers
  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand32(output logic [31:0] val);
    for (int i = 0; i < 32; i++) begin
      val        = {val[30:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic clear_issue();
    issue           = '0;
    issue.pc_vld    = 1'b1;
    issue.info.rv32 = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference models
  function automatic logic [31:0] alu_model(input int op, input logic [31:0] a, b);
    case (op)
      0:       return a + b;
      1:       return a - b;
      2:       return a ^ b;
      3:       return a << b[4:0];
      4:       return a >> b[4:0];
      5:       return $signed(a) >>> b[4:0];
      6:       return a | b;
      7:       return a & b;
      8:       return {31'b0, $signed(a) < $signed(b)};
      9:       return {31'b0, a < b};
      default: return b;                        // LUI
    endcase
  endfunction

  function automatic logic cmp_model(input int k, input logic [31:0] a, b);
    case (k)
      0:       return a == b;
      1:       return a != b;
      2:       return $signed(a) < $signed(b);
      3:       return $signed(a) >= $signed(b);
      4:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Low 64 bits of a product of extended operands
  function automatic logic [31:0] mul_model(input int op, input logic [31:0] a, b);
    logic [63:0] ea, eb, p;
    ea = (op == 1 || op == 2) ? {{32{a[31]}}, a} : {32'b0, a};
    eb = (op == 1) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return (op == 0) ? p[31:0] : p[63:32];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Issue helpers
  task automatic issue_comb(input logic exp_wbck, input logic [31:0] exp_wdat,
                            input logic exp_rslv);
    logic is_bjp;
    logic exp_ilegl;
    exp_ilegl = issue.ilegl | (issue.info.grp == GRP_RSV);  // Reserved group is illegal
    is_bjp    = (issue.info.grp == GRP_BJP) & ~exp_ilegl;
    i_valid   = 1'b1;
    @(negedge clk);
    check("o_ready", o_ready, 1);
    check("o_cmt_valid", o_cmt_valid, 1);
    check("o_wbck_valid", o_wbck_valid, exp_wbck);
    if (exp_wbck) begin
      check("o_wbck_wdat", o_wbck_wdat, exp_wdat);
      check("o_wbck_rdidx", o_wbck_rdidx, issue.rdidx);
    end
    check("o_cmt.bjp", o_cmt.bjp, is_bjp);
    check("o_cmt.bjp_prdt", o_cmt.bjp_prdt, is_bjp & issue.info.pld.bjp.bprdt);
    check("o_cmt.bjp_rslv", o_cmt.bjp_rslv, exp_rslv);
    check("o_cmt.ilegl", o_cmt.ilegl, exp_ilegl);
    check("o_cmt.pc", o_cmt.pc, issue.pc);
    check("o_cmt.pc_vld", o_cmt.pc_vld, issue.pc_vld);
    check("o_cmt.imm", o_cmt.imm, issue.imm);
    check("o_cmt.rv32", o_cmt.rv32, issue.info.rv32);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  // hold is the number of cycles the result waits on a low i_cmt_ready
  task automatic run_mul(input int op, input logic [31:0] a, b, input int hold);
    logic [31:0] exp_wdat;
    int          cycles;
    clear_issue();
    issue.rs1      = a;
    issue.rs2      = b;
    issue.rdwen    = 1'b1;
    issue.rdidx    = 5'd7;
    issue.info.grp = GRP_MULDIV;
    issue.info.pld = DEC_PLD_W'(13'h1000 >> op);  // MUL flag is the top bit
    exp_wdat       = mul_model(op, a, b);
    i_cmt_ready    = (hold == 0);
    i_valid        = 1'b1;
    cycles         = 0;
    @(negedge clk);
    while (!o_cmt_valid) begin
      check("o_ready", o_ready, 0);
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    check("multiply latency", cycles, MUL_STEPS + 1);
    check("o_wbck_wdat", o_wbck_wdat, exp_wdat);
    for (int h = 0; h < hold; h++) begin
      check("o_ready", o_ready, 0);
      check("o_wbck_valid", o_wbck_valid, 0);
      @(posedge clk);
      #1;
      if (h == hold - 1) begin
        i_cmt_ready = 1'b1;
      end
      @(negedge clk);
      check("o_wbck_wdat", o_wbck_wdat, exp_wdat);  // Result must not move
    end
    check("o_ready", o_ready, 1);
    check("o_wbck_valid", o_wbck_valid, 1);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  task automatic test_alu();
    logic [31:0] a, b;
    for (int op = 0; op < 11; op++) begin
      for (int j = 0; j < 4; j++) begin
        clear_issue();
        rand32(issue.rs1);
        rand32(issue.rs2);
        rand32(issue.imm);
        rand32(issue.pc);
        issue.pc_vld   = ~j[0];
        issue.rdwen    = 1'b1;
        issue.rdidx    = RFIDX_W'(op + j + 1);
        issue.info.grp = GRP_ALU;
        issue.info.pld = DEC_PLD_W'(13'h1000 >> op);  // One-hot flag from add downward
        issue.info.pld.alu.op2imm = j[0];
        issue.info.pld.alu.op1pc  = j[1];
        a = j[1] ? issue.pc : issue.rs1;
        b = j[0] ? issue.imm : issue.rs2;
        issue_comb(1'b1, alu_model(op, a, b), 1'b0);
      end
    end
  endtask

  task automatic test_bjp();
    logic [31:0] x, y;
    for (int k = 0; k < 6; k++) begin
      rand32(x);
      rand32(y);
      // Equal pair, then both orders of a distinct pair
      for (int p = 0; p < 3; p++) begin
        clear_issue();
        issue.rs1      = (p == 2) ? y : x;
        issue.rs2      = (p == 1) ? y : x;
        issue.info.grp = GRP_BJP;
        issue.info.pld = DEC_PLD_W'(13'h0800 >> k);  // beq first
        issue.info.pld.bjp.bprdt = p[0];
        issue_comb(1'b0, '0, cmp_model(k, issue.rs1, issue.rs2));
      end
    end
    for (int r = 0; r < 2; r++) begin
      clear_issue();
      rand32(issue.pc);
      issue.rdwen     = 1'b1;
      issue.rdidx     = 5'd1;
      issue.info.grp  = GRP_BJP;
      issue.info.rv32 = ~r[0];                  // Second jump is compressed
      issue.info.pld.bjp.jump  = 1'b1;
      issue.info.pld.bjp.bprdt = 1'b1;
      issue_comb(1'b1, issue.pc + ((r == 0) ? 32'd4 : 32'd2), 1'b1);
    end
  endtask

  task automatic test_mul();
    logic [31:0] a, b;
    for (int op = 0; op < 4; op++) begin
      for (int s = 0; s < 3; s++) begin
        rand32(a);
        rand32(b);
        if (s == 2) begin
          a = 32'h8000_0000;                    // Most negative times -1
          b = 32'hffff_ffff;
        end
        run_mul(op, a, b, 0);
      end
    end
  endtask

  // Flagged ALU and multiply issues, then the reserved group with no flag
  task automatic test_illegal();
    for (int g = 0; g < 3; g++) begin
      clear_issue();
      rand32(issue.rs1);
      issue.ilegl    = (g != 2);
      issue.rdwen    = 1'b1;
      issue.rdidx    = 5'd3;
      issue.info.grp = (g == 0) ? GRP_ALU : (g == 1) ? GRP_MULDIV : GRP_RSV;
      issue.info.pld.alu.add = 1'b1;
      issue_comb(1'b0, '0, 1'b0);
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] a, b;
    rand32(a);
    rand32(b);
    clear_issue();
    issue.rs1      = a;
    issue.rs2      = b;
    issue.rdwen    = 1'b1;
    issue.rdidx    = 5'd9;
    issue.info.grp = GRP_ALU;
    issue.info.pld.alu.xor_op = 1'b1;
    i_cmt_ready = 1'b0;
    i_valid     = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check("o_cmt_valid", o_cmt_valid, 1);
      check("o_wbck_valid", o_wbck_valid, 0);
      check("o_ready", o_ready, 0);
      @(posedge clk);
      #1;
    end
    // Write-back port not ready holds the commit back
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b0;
    @(negedge clk);
    check("o_cmt_valid", o_cmt_valid, 0);
    check("o_wbck_valid", o_wbck_valid, 1);
    check("o_ready", o_ready, 0);
    @(posedge clk);
    #1;
    i_wbck_ready = 1'b1;
    issue_comb(1'b1, a ^ b, 1'b0);
    // No rd write, so commit alone finishes the handshake
    issue.rdwen  = 1'b0;
    i_wbck_ready = 1'b0;
    issue_comb(1'b0, '0, 1'b0);
    i_wbck_ready = 1'b1;
    run_mul(1, a, b, 3);
  endtask

  initial begin
    i_reset      = 1'b1;
    i_valid      = 1'b0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    clear_issue();
    repeat (3) @(posedge clk);
    #1;
    i_reset = 1'b0;
    @(negedge clk);
    check("o_cmt_valid", o_cmt_valid, 0);
    check("o_wbck_valid", o_wbck_valid, 0);
    check("o_ready", o_ready, 0);
    @(posedge clk);
    #1;
    test_alu();
    test_bjp();
    test_mul();
    test_illegal();
    test_backpressure();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: compile.f
exu_alu_pkg.sv
exu_alu_rglr.sv
exu_alu_bjp.sv
exu_alu_muldiv.sv
exu_alu_dpath.sv
exu_alu_retire.sv
exu_alu.sv
tb_exu_alu.sv

// File: Makefile
OBJ = obj_dir

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exu_alu -Mdir $(OBJ) -f compile.f
	./$(OBJ)/Vtb_exu_alu | tee sim.log
	grep -q "Verification passed" sim.log
	! grep -q "Verification failed" sim.log

clean:
	rm -rf $(OBJ) sim.log

.PHONY: sim clean
